// ==== rtl/lc3b_types.sv ====
package lc3b_types;

	typedef logic [15:0] lc3b_word;

	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// indirect ops walk through all three, direct ops stay in phase_first
	typedef enum logic [1:0]
	{
		phase_first = 2'b00,
		phase_gap   = 2'b01,
		phase_final = 2'b10
	} mem_phase;

endpackage : lc3b_types

// ==== rtl/dmem_bus_pkg.sv ====
package dmem_bus_pkg;

	// bit 1 high byte, bit 0 low byte
	typedef logic [1:0] lc3b_mem_wmask;

	// extra wait states before resp
	localparam int default_wait_cycles = 2;

	// word address width of the data ram
	localparam int default_addr_bits = 8;

endpackage : dmem_bus_pkg

// ==== rtl/ex_mem_latch.sv ====
module ex_mem_latch
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    advance,
	input  logic                    flush,
	input  lc3b_types::lc3b_opcode  opcode_in,
	input  lc3b_types::lc3b_word    alu_in,
	input  lc3b_types::lc3b_word    dest_in,
	output logic                    valid,
	output lc3b_types::lc3b_opcode  opcode,
	output lc3b_types::lc3b_word    alu_out,
	output lc3b_types::lc3b_word    dest_out
);

	// new entry wins over an invalidate in the same cycle
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid <= 1'b0;
		end
		else if (advance)
		begin
			valid <= 1'b1;
		end
		else if (flush)
		begin
			valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			opcode   <= opcode_in;
			alu_out  <= alu_in;
			dest_out <= dest_in;
		end
	end

endmodule : ex_mem_latch

// ==== rtl/mem_access_ctrl.sv ====
module mem_access_ctrl
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        load_ex_mem,
	input  logic                        control_flush,
	input  logic                        valid,
	input  lc3b_types::lc3b_opcode      opcode,
	input  lc3b_types::lc3b_word        alu_out,
	input  lc3b_types::lc3b_word        dest_out,
	input  logic                        dmem_resp,
	input  lc3b_types::lc3b_word        dmem_rdata,
	output logic                        dmem_cyc,
	output logic                        dmem_stb,
	output logic                        dmem_write,
	output dmem_bus_pkg::lc3b_mem_wmask dmem_byte_enable,
	output lc3b_types::lc3b_word        dmem_address,
	output lc3b_types::lc3b_word        dmem_wdata,
	output logic                        mem_stall,
	output logic                        advance,
	output logic                        flush,
	output logic                        complete
);

	import lc3b_types::*;

	mem_phase phase;
	lc3b_word pointer;
	logic     is_mem;
	logic     is_ind;
	logic     bus_active;
	logic     bus_resp;
	logic     last_access;

	always_comb
	begin
		is_mem = 1'b0;
		is_ind = 1'b0;
		case (opcode)
			op_ldr, op_str, op_ldb, op_stb, op_trap:
			begin
				is_mem = 1'b1;
			end
			op_ldi, op_sti:
			begin
				is_mem = 1'b1;
				is_ind = 1'b1;
			end
			default:
			begin
				is_mem = 1'b0;
			end
		endcase
	end

	// bus idles in the gap and whenever the entry is being flushed
	assign bus_active  = valid && is_mem && !control_flush && (phase != phase_gap);
	assign bus_resp    = bus_active && dmem_resp;
	assign last_access = !is_ind || (phase == phase_final);

	assign dmem_cyc   = bus_active;
	assign dmem_stb   = bus_active;
	assign dmem_write = bus_active && ((opcode == op_str) || (opcode == op_stb) ||
		((opcode == op_sti) && (phase == phase_final)));

	assign dmem_address = (phase == phase_final) ? pointer : alu_out;

	always_comb
	begin
		dmem_wdata       = dest_out;
		dmem_byte_enable = 2'b11;
		if (opcode == op_stb)
		begin
			dmem_wdata = {dest_out[7:0], dest_out[7:0]};
			if (alu_out[0])
				dmem_byte_enable = 2'b10;
			else
				dmem_byte_enable = 2'b01;
		end
	end

	assign complete  = valid && !control_flush && (!is_mem || (bus_resp && last_access));
	assign mem_stall = valid && is_mem && !control_flush && !(bus_resp && last_access);
	assign advance   = load_ex_mem && !mem_stall;

	// retiring an entry invalidates it unless a new one arrives
	assign flush = control_flush || complete;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			phase <= phase_first;
		end
		else if (control_flush)
		begin
			phase <= phase_first;
		end
		else
		begin
			case (phase)
				phase_first:
				begin
					if (bus_resp && is_ind)
						phase <= phase_gap;
				end
				phase_gap:
				begin
					phase <= phase_final;
				end
				phase_final:
				begin
					if (bus_resp)
						phase <= phase_first;
				end
				default:
				begin
					phase <= phase_first;
				end
			endcase
		end
	end

	// pointer word from the first read of ldi/sti
	always_ff @(posedge clk)
	begin
		if (bus_resp && is_ind && (phase == phase_first))
			pointer <= dmem_rdata;
	end

endmodule : mem_access_ctrl

// ==== rtl/mem_wb_align.sv ====
module mem_wb_align
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    complete,
	input  lc3b_types::lc3b_opcode  opcode,
	input  lc3b_types::lc3b_word    alu_out,
	input  logic                    addr_lsb,
	input  lc3b_types::lc3b_word    dmem_rdata,
	output logic                    wb_valid,
	output lc3b_types::lc3b_opcode  wb_opcode,
	output lc3b_types::lc3b_word    wb_data
);

	import lc3b_types::*;

	logic [7:0] load_byte;
	lc3b_word   result;

	assign load_byte = addr_lsb ? dmem_rdata[15:8] : dmem_rdata[7:0];

	always_comb
	begin
		case (opcode)
			op_ldb:
			begin
				result = {{8{load_byte[7]}}, load_byte};
			end
			op_ldr, op_ldi, op_trap:
			begin
				result = dmem_rdata;
			end
			// alu ops pass through, stores report the address (the pointer for sti)
			default:
			begin
				result = alu_out;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			wb_valid <= 1'b0;
		else
			wb_valid <= complete;
	end

	always_ff @(posedge clk)
	begin
		if (complete)
		begin
			wb_opcode <= opcode;
			wb_data   <= result;
		end
	end

endmodule : mem_wb_align

// ==== rtl/data_ram.sv ====
module data_ram
#(
	parameter int wait_cycles = dmem_bus_pkg::default_wait_cycles,
	parameter int addr_bits   = dmem_bus_pkg::default_addr_bits
)
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        dmem_cyc,
	input  logic                        dmem_stb,
	input  logic                        dmem_write,
	input  dmem_bus_pkg::lc3b_mem_wmask dmem_byte_enable,
	input  lc3b_types::lc3b_word        dmem_address,
	input  lc3b_types::lc3b_word        dmem_wdata,
	output lc3b_types::lc3b_word        dmem_rdata,
	output logic                        dmem_resp
);

	import lc3b_types::*;

	localparam int cnt_bits = $clog2(wait_cycles + 2);

	lc3b_word               mem [2**addr_bits];
	logic [cnt_bits-1:0]    wait_count;
	logic [addr_bits-1:0]   word_index;
	logic                   request;

	assign request    = dmem_cyc && dmem_stb;
	assign word_index = dmem_address[addr_bits:1];

	// counts consecutive strobe cycles, restarts after each resp
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wait_count <= '0;
			dmem_resp  <= 1'b0;
		end
		else
		begin
			dmem_resp <= request && !dmem_resp && (wait_count == cnt_bits'(wait_cycles));
			if (!request || dmem_resp)
				wait_count <= '0;
			else if (wait_count != cnt_bits'(wait_cycles))
				wait_count <= wait_count + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (request && !dmem_resp && (wait_count == cnt_bits'(wait_cycles)))
			dmem_rdata <= mem[word_index];
	end

	// write lands at the end of the resp cycle, if strobe is still up
	always_ff @(posedge clk)
	begin
		if (request && dmem_resp && dmem_write)
		begin
			if (dmem_byte_enable[1])
				mem[word_index][15:8] <= dmem_wdata[15:8];
			if (dmem_byte_enable[0])
				mem[word_index][7:0] <= dmem_wdata[7:0];
		end
	end

endmodule : data_ram

// ==== rtl/mem_stage_top.sv ====
module mem_stage_top
#(
	parameter int wait_cycles = dmem_bus_pkg::default_wait_cycles,
	parameter int addr_bits   = dmem_bus_pkg::default_addr_bits
)
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    load_ex_mem,
	input  logic                    control_flush,
	input  lc3b_types::lc3b_opcode  opcode,
	input  lc3b_types::lc3b_word    alu_out,
	input  lc3b_types::lc3b_word    dest_out,
	output logic                    mem_stall,
	output logic                    wb_valid,
	output lc3b_types::lc3b_opcode  wb_opcode,
	output lc3b_types::lc3b_word    wb_data
);

	import lc3b_types::*;
	import dmem_bus_pkg::*;

	logic          advance;
	logic          flush;
	logic          complete;
	logic          ex_valid;
	lc3b_opcode    ex_opcode;
	lc3b_word      ex_alu;
	lc3b_word      ex_dest;
	logic          dmem_cyc;
	logic          dmem_stb;
	logic          dmem_write;
	lc3b_mem_wmask dmem_byte_enable;
	lc3b_word      dmem_address;
	lc3b_word      dmem_wdata;
	lc3b_word      dmem_rdata;
	logic          dmem_resp;

	ex_mem_latch ex_mem
	(
		.clk       (clk),
		.rst       (rst),
		.advance   (advance),
		.flush     (flush),
		.opcode_in (opcode),
		.alu_in    (alu_out),
		.dest_in   (dest_out),
		.valid     (ex_valid),
		.opcode    (ex_opcode),
		.alu_out   (ex_alu),
		.dest_out  (ex_dest)
	);

	mem_access_ctrl ctrl
	(
		.clk              (clk),
		.rst              (rst),
		.load_ex_mem      (load_ex_mem),
		.control_flush    (control_flush),
		.valid            (ex_valid),
		.opcode           (ex_opcode),
		.alu_out          (ex_alu),
		.dest_out         (ex_dest),
		.dmem_resp        (dmem_resp),
		.dmem_rdata       (dmem_rdata),
		.dmem_cyc         (dmem_cyc),
		.dmem_stb         (dmem_stb),
		.dmem_write       (dmem_write),
		.dmem_byte_enable (dmem_byte_enable),
		.dmem_address     (dmem_address),
		.dmem_wdata       (dmem_wdata),
		.mem_stall        (mem_stall),
		.advance          (advance),
		.flush            (flush),
		.complete         (complete)
	);

	// muxed address doubles as the store address for writeback
	mem_wb_align wb
	(
		.clk        (clk),
		.rst        (rst),
		.complete   (complete),
		.opcode     (ex_opcode),
		.alu_out    (dmem_address),
		.addr_lsb   (dmem_address[0]),
		.dmem_rdata (dmem_rdata),
		.wb_valid   (wb_valid),
		.wb_opcode  (wb_opcode),
		.wb_data    (wb_data)
	);

	data_ram #(
		.wait_cycles (wait_cycles),
		.addr_bits   (addr_bits)
	) ram
	(
		.clk              (clk),
		.rst              (rst),
		.dmem_cyc         (dmem_cyc),
		.dmem_stb         (dmem_stb),
		.dmem_write       (dmem_write),
		.dmem_byte_enable (dmem_byte_enable),
		.dmem_address     (dmem_address),
		.dmem_wdata       (dmem_wdata),
		.dmem_rdata       (dmem_rdata),
		.dmem_resp        (dmem_resp)
	);

endmodule : mem_stage_top

// ==== sim/tb_mem_stage.sv ====
module tb_mem_stage;

	timeunit 1ns;
	timeprecision 1ps;

	import lc3b_types::*;
	import dmem_bus_pkg::*;

	localparam int wait_cycles    = 2;
	localparam int addr_bits      = default_addr_bits;
	localparam int max_wait       = 64;
	localparam int single_stall   = wait_cycles + 1;
	localparam int indirect_stall = 2 * (wait_cycles + 1) + 2;

	logic       clk;
	logic       rst;
	logic       load_ex_mem;
	logic       control_flush;
	lc3b_opcode opcode;
	lc3b_word   alu_out;
	lc3b_word   dest_out;
	logic       mem_stall;
	logic       wb_valid;
	lc3b_opcode wb_opcode;
	lc3b_word   wb_data;

	lc3b_word   model_mem [2**addr_bits];
	lc3b_opcode exp_op_q [$];
	lc3b_word   exp_data_q [$];
	lc3b_opcode head_op;
	lc3b_word   head_data;
	int         wb_errors      = 0;
	int         stall_errors   = 0;
	int         latency_errors = 0;
	int         timeout_count  = 0;

	mem_stage_top #(
		.wait_cycles (wait_cycles),
		.addr_bits   (addr_bits)
	) dut
	(
		.clk           (clk),
		.rst           (rst),
		.load_ex_mem   (load_ex_mem),
		.control_flush (control_flush),
		.opcode        (opcode),
		.alu_out       (alu_out),
		.dest_out      (dest_out),
		.mem_stall     (mem_stall),
		.wb_valid      (wb_valid),
		.wb_opcode     (wb_opcode),
		.wb_data       (wb_data)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic report_mismatch(string name, lc3b_word expected, lc3b_word actual);
		$display("[FAIL] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
	endtask

	function automatic logic [addr_bits-1:0] word_of(lc3b_word addr);
		return addr[addr_bits:1];
	endfunction

	function automatic lc3b_word sext_lane(lc3b_word word, logic odd);
		logic [7:0] lane;
		lane = odd ? word[15:8] : word[7:0];
		return {{8{lane[7]}}, lane};
	endfunction

	function automatic lc3b_word merge_lane(lc3b_word old, logic odd, logic [7:0] lane);
		lc3b_word word;
		word = old;
		if (odd)
			word[15:8] = lane;
		else
			word[7:0] = lane;
		return word;
	endfunction

	function automatic lc3b_word rand_word_addr();
		return lc3b_word'(($urandom % (2**addr_bits)) * 2);
	endfunction

	// oldest outstanding result is matched on each writeback
	always @(negedge clk)
	begin
		if (!rst && wb_valid)
		begin
			if (exp_op_q.size() == 0)
			begin
				wb_errors++;
				$display("%0t ns: wb_valid with no instruction outstanding", $time);
			end
			else
			begin
				head_op   = exp_op_q.pop_front();
				head_data = exp_data_q.pop_front();
				assert (wb_opcode == head_op)
				else
				begin
					wb_errors++;
					report_mismatch("wb_opcode", lc3b_word'(head_op), lc3b_word'(wb_opcode));
				end
				assert (wb_data == head_data)
				else
				begin
					wb_errors++;
					report_mismatch("wb_data", head_data, wb_data);
				end
			end
		end
	end

	task automatic issue(lc3b_opcode op, lc3b_word alu, lc3b_word dest);
		int n;
		n = 0;
		@(negedge clk);
		while (mem_stall && n < max_wait)
		begin
			@(negedge clk);
			n++;
		end
		if (mem_stall)
		begin
			timeout_count++;
			$display("%0t ns: mem_stall stuck high before issue", $time);
		end
		@(posedge clk);
		load_ex_mem <= 1'b1;
		opcode      <= op;
		alu_out     <= alu;
		dest_out    <= dest;
		@(posedge clk);
		load_ex_mem <= 1'b0;
	endtask

	task automatic run_instr(lc3b_opcode op, lc3b_word alu, lc3b_word dest);
		logic [addr_bits-1:0] idx;
		lc3b_word             ptr;
		lc3b_word             expected;
		int                   stall_n;
		int                   k;
		logic                 seen;
		logic                 exp_stall;
		idx      = word_of(alu);
		ptr      = model_mem[idx];
		expected = alu;
		stall_n  = single_stall;
		case (op)
			op_str:
			begin
				model_mem[idx] = dest;
			end
			op_stb:
			begin
				model_mem[idx] = merge_lane(model_mem[idx], alu[0], dest[7:0]);
			end
			op_ldr, op_trap:
			begin
				expected = model_mem[idx];
			end
			op_ldb:
			begin
				expected = sext_lane(model_mem[idx], alu[0]);
			end
			op_ldi:
			begin
				expected = model_mem[word_of(ptr)];
				stall_n  = indirect_stall;
			end
			op_sti:
			begin
				expected = ptr;
				model_mem[word_of(ptr)] = dest;
				stall_n  = indirect_stall;
			end
			default:
			begin
				stall_n = 0;
			end
		endcase
		exp_op_q.push_back(op);
		exp_data_q.push_back(expected);
		issue(op, alu, dest);
		k    = 0;
		seen = 1'b0;
		while (!seen && k < max_wait)
		begin
			@(negedge clk);
			k++;
			seen      = wb_valid;
			// low in the last resp cycle and after
			exp_stall = !seen && (k <= stall_n);
			assert (mem_stall == exp_stall)
			else
			begin
				stall_errors++;
				report_mismatch("mem_stall", lc3b_word'(exp_stall), lc3b_word'(mem_stall));
			end
		end
		if (!seen)
		begin
			timeout_count++;
			$display("%0t ns: no wb_valid within %0d cycles for opcode %h", $time, max_wait, op);
		end
		else if (k != stall_n + 2)
		begin
			latency_errors++;
			$display("%0t ns: wb_valid came %0d cycles after load, expected %0d",
				$time, k, stall_n + 2);
		end
	endtask

	task automatic run_flushed(lc3b_opcode op, lc3b_word alu, lc3b_word dest, int flush_at);
		int k;
		issue(op, alu, dest);
		for (k = 1; k < flush_at; k++)
		begin
			@(negedge clk);
			assert (mem_stall)
			else
			begin
				stall_errors++;
				report_mismatch("mem_stall", 16'd1, 16'd0);
			end
		end
		@(posedge clk);
		control_flush <= 1'b1;
		@(negedge clk);
		assert (!mem_stall)
		else
		begin
			stall_errors++;
			report_mismatch("mem_stall", 16'd0, 16'd1);
		end
		@(posedge clk);
		control_flush <= 1'b0;
	endtask

	initial
	begin
		int       i;
		lc3b_word a;
		lc3b_word p;
		lc3b_word t;
		lc3b_word v;
		void'($urandom(32'h06d6_951f));
		rst           <= 1'b1;
		load_ex_mem   <= 1'b0;
		control_flush <= 1'b0;
		opcode        <= op_br;
		alu_out       <= 16'h0000;
		dest_out      <= 16'h0000;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (!mem_stall)
		else
		begin
			stall_errors++;
			report_mismatch("mem_stall", 16'd0, 16'd1);
		end
		assert (!wb_valid)
		else
		begin
			wb_errors++;
			report_mismatch("wb_valid", 16'd0, 16'd1);
		end

		for (i = 0; i < 4; i++)
		begin
			run_instr(op_add, lc3b_word'($urandom), lc3b_word'($urandom));
			run_instr(op_lea, lc3b_word'($urandom), lc3b_word'($urandom));
		end

		// word store, then one byte lane on top
		for (i = 0; i < 6; i++)
		begin
			a = rand_word_addr();
			run_instr(op_str, a, lc3b_word'($urandom));
			run_instr(op_stb, a | lc3b_word'(i % 2), lc3b_word'($urandom));
			run_instr(op_ldr, a, 16'h0000);
			run_instr(op_trap, a, 16'h0000);
		end

		for (i = 0; i < 4; i++)
		begin
			a = rand_word_addr();
			v = lc3b_word'($urandom);
			v[15] = i[0];
			v[7]  = !i[0];
			run_instr(op_str, a, v);
			run_instr(op_ldb, a, 16'h0000);
			run_instr(op_ldb, a | 16'h0001, 16'h0000);
		end

		for (i = 0; i < 4; i++)
		begin
			p = rand_word_addr();
			t = rand_word_addr();
			if (t == p)
				t = t ^ 16'h0002;
			run_instr(op_str, t, lc3b_word'($urandom));
			run_instr(op_str, p, t);
			run_instr(op_sti, p, lc3b_word'($urandom));
			run_instr(op_ldr, t, 16'h0000);
			run_instr(op_ldi, p, 16'h0000);
			run_instr(op_ldr, p, 16'h0000);
		end

		// flushed str leaves the old word in memory
		a = rand_word_addr();
		run_instr(op_str, a, lc3b_word'($urandom));
		run_flushed(op_str, a, ~model_mem[word_of(a)], 2 + int'($urandom % (wait_cycles + 1)));
		run_instr(op_ldr, a, 16'h0000);

		// sti flushed in the gap after the pointer read
		p = rand_word_addr();
		t = rand_word_addr();
		if (t == p)
			t = t ^ 16'h0002;
		run_instr(op_str, t, lc3b_word'($urandom));
		run_instr(op_str, p, t);
		run_flushed(op_sti, p, ~model_mem[word_of(t)], wait_cycles + 3);
		run_instr(op_ldr, t, 16'h0000);
		run_instr(op_ldr, p, 16'h0000);
		run_instr(op_ldi, p, 16'h0000);

		repeat (4) @(posedge clk);
		if (exp_op_q.size() != 0)
		begin
			latency_errors++;
			$display("%0d results were never written back", exp_op_q.size());
		end
		$display("errors: writeback %0d, stall %0d, latency %0d, timeout %0d",
			wb_errors, stall_errors, latency_errors, timeout_count);
		if (wb_errors + stall_errors + latency_errors + timeout_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule : tb_mem_stage

// ==== vlog.f ====
rtl/lc3b_types.sv
rtl/dmem_bus_pkg.sv
rtl/ex_mem_latch.sv
rtl/mem_access_ctrl.sv
rtl/mem_wb_align.sv
rtl/data_ram.sv
rtl/mem_stage_top.sv
sim/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_mem_stage -f vlog.f

./obj_dir/Vtb_mem_stage | tee sim.log

if grep -qx "Regression passed" sim.log; then
	exit 0
else
	echo "simulation did not pass, see sim.log"
	exit 1
fi
